/* hdl/ex_pkg.sv */
`default_nettype none

package ex_pkg;

  // Datapath and register index widths
  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  // One restoring step per result bit
  localparam int DIV_CYCLES = XLEN;
  localparam int DIV_CNT_W = $clog2(DIV_CYCLES + 1);

  // addi x0, x0, 0
  localparam logic [31:0] I_NOP = 32'h0000_0013;

  typedef logic [XLEN-1:0] word_t;

  // Operation applied by the ALU datapath
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } alu_op_t;

  // Coarse ALU class coming from ID
  typedef enum logic [1:0] {
    ALU_ADD    = 2'b00,
    ALU_BRANCH = 2'b01,
    ALU_FUNCT  = 2'b10
  } alu_instr_t;

  typedef enum logic [1:0] {
    ALU_A_RS1  = 2'b00,
    ALU_A_ZERO = 2'b01,
    ALU_A_PC   = 2'b10
  } alu_a_sel_t;

  // PREDICTED is never driven by this stage
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'b00,
    PC_SEL_PREDICTED  = 2'b01,
    PC_SEL_REDIRECT   = 2'b10
  } pc_sel_t;

  // Branch funct3
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // M extension divide funct3
  localparam logic [2:0] F3_DIV = 3'b100;
  localparam logic [2:0] F3_DIVU = 3'b101;
  localparam logic [2:0] F3_REM = 3'b110;
  localparam logic [2:0] F3_REMU = 3'b111;

  // Control bits decoded in ID
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    alu_a_sel_t alu_a_src;
    logic       alu_b_src;
    alu_instr_t alu_instr;
    logic [2:0] res_src;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       jb_target_src;
    logic       is_mc;
  } ex_ctrl_t;

  // ID/EX register contents, operands already resolved
  typedef struct packed {
    ex_ctrl_t              ctrl;
    logic [31:0]           instr;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs2;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    word_t                 rs1_data;
    word_t                 rs2_data;
    word_t                 imm;
    word_t                 pc;
    word_t                 pc_plus4;
  } id_ex_t;

  // EX/MEM register contents
  typedef struct packed {
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic [2:0]            res_src;
    logic [31:0]           instr;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs2;
    logic [2:0]            funct3;
    word_t                 alu_result;
    word_t                 rs1_data;
    word_t                 rs2_data;
    word_t                 pc_plus4;
    word_t                 jb_target;
    word_t                 m_result;
    logic                  is_jalr;
    logic                  trap;
  } ex_mem_t;

endpackage

`default_nettype wire

/* hdl/ex_alu.sv */
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_instr_t alu_instr,
  input  logic [2:0]         funct3,
  input  logic               funct7_b5,
  input  logic               op_b5,
  input  ex_pkg::word_t      a,
  input  ex_pkg::word_t      b,
  output ex_pkg::word_t      result
);

  ex_pkg::alu_op_t alu_op;
  logic [$clog2(ex_pkg::XLEN)-1:0] shamt;

  // Decoder
  always_comb begin
    alu_op = ex_pkg::ADD;
    case (alu_instr)
      // Address generation for loads, stores, AUIPC
      ex_pkg::ALU_ADD: alu_op = ex_pkg::ADD;
      // Branches compare by subtraction
      ex_pkg::ALU_BRANCH: alu_op = ex_pkg::SUB;
      ex_pkg::ALU_FUNCT: begin
        case (funct3)
          // SUB only exists in register-register form
          3'b000: alu_op = (funct7_b5 && op_b5) ? ex_pkg::SUB : ex_pkg::ADD;
          3'b001: alu_op = ex_pkg::SLL;
          3'b010: alu_op = ex_pkg::SLT;
          3'b011: alu_op = ex_pkg::SLTU;
          3'b100: alu_op = ex_pkg::XOR;
          // SRAI also carries funct7 bit 5 in the immediate
          3'b101: alu_op = funct7_b5 ? ex_pkg::SRA : ex_pkg::SRL;
          3'b110: alu_op = ex_pkg::OR;
          default: alu_op = ex_pkg::AND;
        endcase
      end
      default: alu_op = ex_pkg::ADD;
    endcase
  end

  // Shift amount is the low bits of operand B
  assign shamt = b[$clog2(ex_pkg::XLEN)-1:0];

  // Datapath
  always_comb begin
    case (alu_op)
      ex_pkg::ADD: result = a + b;
      ex_pkg::SUB: result = a - b;
      ex_pkg::SLL: result = a << shamt;
      ex_pkg::SLT: begin
        result = {{(ex_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      end
      ex_pkg::SLTU: result = {{(ex_pkg::XLEN-1){1'b0}}, a < b};
      ex_pkg::XOR: result = a ^ b;
      ex_pkg::SRL: result = a >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::SRA: result = ex_pkg::word_t'($signed(a) >>> shamt);
      ex_pkg::OR: result = a | b;
      ex_pkg::AND: result = a & b;
      default: result = a + b;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_branch_unit.sv */
`default_nettype none

module ex_branch_unit (
  input  ex_pkg::ex_ctrl_t ctrl,
  input  logic [2:0]       funct3,
  input  ex_pkg::word_t    rs1_data,
  input  ex_pkg::word_t    rs2_data,
  input  ex_pkg::word_t    pc,
  input  ex_pkg::word_t    imm,
  input  ex_pkg::word_t    alu_result,
  output ex_pkg::word_t    jb_target,
  output logic             trap,
  output ex_pkg::pc_sel_t  pc_sel,
  output ex_pkg::word_t    redirect_target
);

  logic eq;
  logic lt;
  logic ltu;
  logic taken;
  logic jb_active;

  // Comparator shared by all branch conditions
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      ex_pkg::F3_BEQ: taken = eq;
      ex_pkg::F3_BNE: taken = !eq;
      ex_pkg::F3_BLT: taken = lt;
      ex_pkg::F3_BGE: taken = !lt;
      ex_pkg::F3_BLTU: taken = ltu;
      ex_pkg::F3_BGEU: taken = !ltu;
      // Undefined encodings never branch
      default: taken = 1'b0;
    endcase
  end

  // JALR takes rs1 + imm from the ALU, bit 0 forced low
  // JAL and branches are PC relative on their own adder
  always_comb begin
    if (ctrl.jb_target_src) begin
      jb_target = {alu_result[ex_pkg::XLEN-1:1], 1'b0};
    end else begin
      jb_target = pc + imm;
    end
  end

  // Any control transfer that actually leaves the sequential path
  assign jb_active = (ctrl.is_branch && taken) || ctrl.is_jal || ctrl.is_jalr;

  // No compressed support, so the target must be word aligned
  assign trap = jb_active && (|jb_target[1:0]);

  always_comb begin
    if (jb_active) begin
      pc_sel = ex_pkg::PC_SEL_REDIRECT;
    end else begin
      pc_sel = ex_pkg::PC_SEL_SEQUENTIAL;
    end
  end

  assign redirect_target = jb_target;

endmodule

`default_nettype wire

/* hdl/ex_divider.sv */
`default_nettype none

module ex_divider (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,
  input  ex_pkg::word_t rs1,
  input  ex_pkg::word_t rs2,
  input  logic [2:0]    funct3,
  output logic          busy,
  output ex_pkg::word_t result
);

  logic signed_op;
  logic rem_op;
  logic a_neg;
  logic b_neg;
  ex_pkg::word_t a_mag;
  ex_pkg::word_t b_mag;

  logic [ex_pkg::DIV_CNT_W-1:0] count;

  // Iteration state
  ex_pkg::word_t quo;
  ex_pkg::word_t rem;
  ex_pkg::word_t divisor;
  logic neg_q;
  logic neg_r;
  logic is_rem;

  // One bit wider than XLEN so the borrow shows up in the top bit
  logic [ex_pkg::XLEN:0] rem_shift;
  logic [ex_pkg::XLEN:0] diff;

  // Operation decode
  assign signed_op = (funct3 == ex_pkg::F3_DIV) || (funct3 == ex_pkg::F3_REM);
  assign rem_op    = (funct3 == ex_pkg::F3_REM) || (funct3 == ex_pkg::F3_REMU);

  // Magnitudes for the unsigned core
  assign a_neg = signed_op && rs1[ex_pkg::XLEN-1];
  assign b_neg = signed_op && rs2[ex_pkg::XLEN-1];
  assign a_mag = a_neg ? -rs1 : rs1;
  assign b_mag = b_neg ? -rs2 : rs2;

  // Iteration counter and busy flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy  <= 1'b1;
      count <= ex_pkg::DIV_CNT_W'(ex_pkg::DIV_CYCLES);
    end else if (busy) begin
      count <= count - 1'b1;
      // Last step runs this cycle
      if (count == ex_pkg::DIV_CNT_W'(1)) begin
        busy <= 1'b0;
      end
    end
  end

  // Restoring step, dividend bits shift out of quo into rem
  assign rem_shift = {rem, quo[ex_pkg::XLEN-1]};
  assign diff      = rem_shift - {1'b0, divisor};

  always_ff @(posedge clk) begin
    if (start) begin
      quo     <= a_mag;
      rem     <= '0;
      divisor <= b_mag;
      // Zero divisor keeps the all ones quotient unsigned
      neg_q   <= (a_neg ^ b_neg) && (|rs2);
      // Remainder takes the sign of the dividend
      neg_r   <= a_neg;
      is_rem  <= rem_op;
    end else if (busy) begin
      quo <= {quo[ex_pkg::XLEN-2:0], ~diff[ex_pkg::XLEN]};
      if (diff[ex_pkg::XLEN]) begin
        rem <= rem_shift[ex_pkg::XLEN-1:0];
      end else begin
        rem <= diff[ex_pkg::XLEN-1:0];
      end
    end
  end

  // Sign correction on the way out
  // Divide by zero falls out as all ones and the dividend
  // Most negative / -1 gives |a| = 2^(XLEN-1) with no negation, i.e. the dividend
  always_comb begin
    if (is_rem) begin
      result = neg_r ? -rem : rem;
    end else begin
      result = neg_q ? -quo : quo;
    end
  end

endmodule

`default_nettype wire

/* hdl/ex_mem_reg.sv */
`default_nettype none

module ex_mem_reg (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            stall,
  input  logic            flush,
  input  ex_pkg::ex_mem_t d,
  output ex_pkg::ex_mem_t q
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Come out of reset holding a bubble
      q       <= '0;
      q.instr <= ex_pkg::I_NOP;
    end else if (!stall) begin
      q <= d;
      // Flush squashes side effects but keeps the payload
      if (flush) begin
        q.reg_write <= 1'b0;
        q.mem_read  <= 1'b0;
        q.mem_write <= 1'b0;
        q.instr     <= ex_pkg::I_NOP;
      end
    end
    // Stall holds every field
  end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`default_nettype none

module ex_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::id_ex_t  id_ex,
  input  logic            ex_mem_stall,
  input  logic            ex_mem_flush,
  output ex_pkg::ex_mem_t ex_mem,
  output ex_pkg::pc_sel_t pc_sel,
  output ex_pkg::word_t   pc_redirect_target,
  output logic            op_active
);

  typedef enum logic {
    MC_IDLE,
    MC_EXEC
  } mc_state_t;

  mc_state_t mc_state;
  mc_state_t mc_state_next;

  ex_pkg::word_t alu_a;
  ex_pkg::word_t alu_b;
  ex_pkg::word_t alu_result;
  ex_pkg::word_t jb_target;
  ex_pkg::word_t div_result;
  logic trap;
  logic div_start;
  logic div_busy;

  ex_pkg::ex_mem_t ex_mem_d;

  // Operand A source
  always_comb begin
    case (id_ex.ctrl.alu_a_src)
      ex_pkg::ALU_A_RS1: alu_a = id_ex.rs1_data;
      ex_pkg::ALU_A_PC: alu_a = id_ex.pc;
      // LUI adds the immediate to zero
      default: alu_a = '0;
    endcase
  end

  // Operand B is the register or the immediate
  assign alu_b = id_ex.ctrl.alu_b_src ? id_ex.imm : id_ex.rs2_data;

  ex_alu u_alu (
    .alu_instr(id_ex.ctrl.alu_instr),
    .funct3   (id_ex.funct3),
    .funct7_b5(id_ex.funct7[5]),
    .op_b5    (id_ex.instr[5]),
    .a        (alu_a),
    .b        (alu_b),
    .result   (alu_result)
  );

  ex_branch_unit u_branch (
    .ctrl           (id_ex.ctrl),
    .funct3         (id_ex.funct3),
    .rs1_data       (id_ex.rs1_data),
    .rs2_data       (id_ex.rs2_data),
    .pc             (id_ex.pc),
    .imm            (id_ex.imm),
    .alu_result     (alu_result),
    .jb_target      (jb_target),
    .trap           (trap),
    .pc_sel         (pc_sel),
    .redirect_target(pc_redirect_target)
  );

  // Multi-cycle control
  // IDLE launches the divider, EXEC waits for busy to drop
  always_comb begin
    mc_state_next = mc_state;
    op_active     = 1'b0;
    div_start     = 1'b0;
    case (mc_state)
      MC_IDLE: begin
        if (id_ex.ctrl.is_mc) begin
          div_start     = 1'b1;
          op_active     = 1'b1;
          mc_state_next = MC_EXEC;
        end
      end
      MC_EXEC: begin
        if (div_busy) begin
          op_active = 1'b1;
        end else begin
          // Result is ready, let the pipeline capture it
          mc_state_next = MC_IDLE;
        end
      end
      default: mc_state_next = MC_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mc_state <= MC_IDLE;
    end else begin
      mc_state <= mc_state_next;
    end
  end

  ex_divider u_div (
    .clk   (clk),
    .rst_n (rst_n),
    .start (div_start),
    .rs1   (id_ex.rs1_data),
    .rs2   (id_ex.rs2_data),
    .funct3(id_ex.funct3),
    .busy  (div_busy),
    .result(div_result)
  );

  // Next EX/MEM value
  always_comb begin
    ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
    ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
    ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
    ex_mem_d.res_src    = id_ex.ctrl.res_src;
    ex_mem_d.instr      = id_ex.instr;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.rs2        = id_ex.rs2;
    ex_mem_d.funct3     = id_ex.funct3;
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.rs1_data   = id_ex.rs1_data;
    ex_mem_d.rs2_data   = id_ex.rs2_data;
    ex_mem_d.pc_plus4   = id_ex.pc_plus4;
    ex_mem_d.jb_target  = jb_target;
    // Divider output only means something for multi-cycle ops
    ex_mem_d.m_result   = id_ex.ctrl.is_mc ? div_result : '0;
    ex_mem_d.is_jalr    = id_ex.ctrl.is_jalr;
    ex_mem_d.trap       = trap;
  end

  ex_mem_reg u_ex_mem (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(ex_mem_stall),
    .flush(ex_mem_flush),
    .d    (ex_mem_d),
    .q    (ex_mem)
  );

endmodule

`default_nettype wire

/* test/ex_stage_asserts.sv */
`default_nettype none

module ex_stage_asserts (
  input logic            clk,
  input logic            rst_n,
  input ex_pkg::id_ex_t  id_ex,
  input logic            ex_mem_stall,
  input ex_pkg::ex_mem_t ex_mem,
  input ex_pkg::pc_sel_t pc_sel,
  input logic            op_active
);

  // First cycle out of reset starts idle
  op_active_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !op_active)
    else $error("op_active high right after reset");

  // Reserved PC select code never shows, redirect only for a jump or branch
  no_predicted_sel: assert property (@(posedge clk) disable iff (!rst_n)
    pc_sel == ex_pkg::PC_SEL_SEQUENTIAL ||
    (pc_sel == ex_pkg::PC_SEL_REDIRECT &&
     (id_ex.ctrl.is_branch || id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr)))
    else $error("pc_sel took the reserved code or redirected without a jump or branch");

  // Register holds while stalled
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    ex_mem_stall |=> $stable(ex_mem))
    else $error("ex_mem changed under stall");

endmodule

bind ex_stage ex_stage_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .id_ex       (id_ex),
  .ex_mem_stall(ex_mem_stall),
  .ex_mem      (ex_mem),
  .pc_sel      (pc_sel),
  .op_active   (op_active)
);

`default_nettype wire

/* test/ex_checker.sv */
`default_nettype none

module ex_checker (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::id_ex_t  id_ex,
  input  logic            ex_mem_stall,
  input  logic            ex_mem_flush,
  input  ex_pkg::ex_mem_t ex_mem,
  input  ex_pkg::pc_sel_t pc_sel,
  input  ex_pkg::word_t   pc_redirect_target,
  input  logic            op_active,
  output int              errors
);

  ex_pkg::ex_mem_t exp_q;
  logic exp_valid = 1'b0;
  int active_cnt = 0;

  initial errors = 0;

  // ALU result by the RV32I rules
  function automatic ex_pkg::word_t ref_alu(input ex_pkg::id_ex_t t);
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    logic [4:0] sh;
    if (t.ctrl.alu_a_src == ex_pkg::ALU_A_RS1) a = t.rs1_data;
    else if (t.ctrl.alu_a_src == ex_pkg::ALU_A_PC) a = t.pc;
    else a = '0;
    b = t.ctrl.alu_b_src ? t.imm : t.rs2_data;
    sh = b[4:0];
    if (t.ctrl.alu_instr == ex_pkg::ALU_BRANCH) return a - b;
    if (t.ctrl.alu_instr != ex_pkg::ALU_FUNCT) return a + b;
    case (t.funct3)
      3'd0: return (t.funct7[5] && t.instr[5]) ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return t.funct7[5] ? ex_pkg::word_t'($signed(a) >>> sh) : a >> sh;
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // M extension divide, including the zero and overflow cases
  function automatic ex_pkg::word_t ref_div(input logic [2:0] f3, input ex_pkg::word_t a,
                                            input ex_pkg::word_t b);
    logic is_rem;
    logic is_signed;
    is_rem = (f3 == ex_pkg::F3_REM) || (f3 == ex_pkg::F3_REMU);
    is_signed = (f3 == ex_pkg::F3_DIV) || (f3 == ex_pkg::F3_REM);
    if (b == 0) return is_rem ? a : '1;
    if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) return is_rem ? '0 : a;
    if (is_signed) begin
      return is_rem ? ex_pkg::word_t'($signed(a) % $signed(b))
                    : ex_pkg::word_t'($signed(a) / $signed(b));
    end
    return is_rem ? a % b : a / b;
  endfunction

  function automatic logic ref_taken(input ex_pkg::id_ex_t t);
    case (t.funct3)
      ex_pkg::F3_BEQ: return t.rs1_data == t.rs2_data;
      ex_pkg::F3_BNE: return t.rs1_data != t.rs2_data;
      ex_pkg::F3_BLT: return $signed(t.rs1_data) < $signed(t.rs2_data);
      ex_pkg::F3_BGE: return $signed(t.rs1_data) >= $signed(t.rs2_data);
      ex_pkg::F3_BLTU: return t.rs1_data < t.rs2_data;
      ex_pkg::F3_BGEU: return t.rs1_data >= t.rs2_data;
      default: return 1'b0;
    endcase
  endfunction

  // JALR is rs1 + imm with bit 0 cleared, everything else pc relative
  function automatic ex_pkg::word_t ref_target(input ex_pkg::id_ex_t t);
    if (t.ctrl.is_jalr) return (t.rs1_data + t.imm) & ~32'd1;
    return t.pc + t.imm;
  endfunction

  function automatic logic ref_redirect(input ex_pkg::id_ex_t t);
    return t.ctrl.is_jal || t.ctrl.is_jalr || (t.ctrl.is_branch && ref_taken(t));
  endfunction

  // Expected EX/MEM contents after this id_ex is captured
  function automatic ex_pkg::ex_mem_t expect_ex_mem(input ex_pkg::id_ex_t t);
    ex_pkg::ex_mem_t e;
    e = '0;
    e.reg_write = t.ctrl.reg_write;
    e.mem_read = t.ctrl.mem_read;
    e.mem_write = t.ctrl.mem_write;
    e.res_src = t.ctrl.res_src;
    e.instr = t.instr;
    e.rd = t.rd;
    e.rs2 = t.rs2;
    e.funct3 = t.funct3;
    e.alu_result = ref_alu(t);
    e.rs1_data = t.rs1_data;
    e.rs2_data = t.rs2_data;
    e.pc_plus4 = t.pc_plus4;
    e.jb_target = ref_target(t);
    e.m_result = t.ctrl.is_mc ? ref_div(t.funct3, t.rs1_data, t.rs2_data) : '0;
    e.is_jalr = t.ctrl.is_jalr;
    e.trap = ref_redirect(t) && (e.jb_target[1:0] != 2'b00);
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Model of the register, updated on the same edge as the DUT
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q = '0;
      exp_q.instr = ex_pkg::I_NOP;
      exp_valid = 1'b1;
    end else if (!ex_mem_stall) begin
      exp_q = expect_ex_mem(id_ex);
      if (ex_mem_flush) begin
        exp_q.reg_write = 1'b0;
        exp_q.mem_read = 1'b0;
        exp_q.mem_write = 1'b0;
        exp_q.instr = ex_pkg::I_NOP;
      end
    end
  end

  // Compare mid-cycle where everything has settled
  always @(negedge clk) begin
    if (exp_valid) begin
      check_value("ex_mem.reg_write", 32'(ex_mem.reg_write), 32'(exp_q.reg_write));
      check_value("ex_mem.mem_read", 32'(ex_mem.mem_read), 32'(exp_q.mem_read));
      check_value("ex_mem.mem_write", 32'(ex_mem.mem_write), 32'(exp_q.mem_write));
      check_value("ex_mem.res_src", 32'(ex_mem.res_src), 32'(exp_q.res_src));
      check_value("ex_mem.instr", ex_mem.instr, exp_q.instr);
      check_value("ex_mem.rd", 32'(ex_mem.rd), 32'(exp_q.rd));
      check_value("ex_mem.rs2", 32'(ex_mem.rs2), 32'(exp_q.rs2));
      check_value("ex_mem.funct3", 32'(ex_mem.funct3), 32'(exp_q.funct3));
      check_value("ex_mem.alu_result", ex_mem.alu_result, exp_q.alu_result);
      check_value("ex_mem.rs1_data", ex_mem.rs1_data, exp_q.rs1_data);
      check_value("ex_mem.rs2_data", ex_mem.rs2_data, exp_q.rs2_data);
      check_value("ex_mem.pc_plus4", ex_mem.pc_plus4, exp_q.pc_plus4);
      check_value("ex_mem.jb_target", ex_mem.jb_target, exp_q.jb_target);
      check_value("ex_mem.m_result", ex_mem.m_result, exp_q.m_result);
      check_value("ex_mem.is_jalr", 32'(ex_mem.is_jalr), 32'(exp_q.is_jalr));
      check_value("ex_mem.trap", 32'(ex_mem.trap), 32'(exp_q.trap));
    end
    if (rst_n) begin
      // Redirect outputs are combinational on the current id_ex
      check_value("pc_sel", 32'(pc_sel),
                  ref_redirect(id_ex) ? 32'(ex_pkg::PC_SEL_REDIRECT)
                                      : 32'(ex_pkg::PC_SEL_SEQUENTIAL));
      if (ref_redirect(id_ex)) begin
        check_value("pc_redirect_target", pc_redirect_target, ref_target(id_ex));
      end
      // Length of each op_active window
      if (op_active) begin
        active_cnt++;
      end else if (active_cnt != 0) begin
        if (active_cnt != ex_pkg::DIV_CYCLES + 1) begin
          $display("op_active stayed high for %0d cycles instead of %0d at %0t",
                   active_cnt, ex_pkg::DIV_CYCLES + 1, $time);
          errors++;
        end
        active_cnt = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* test/ex_stage_tb.sv */
`default_nettype none

module ex_stage_tb;

  localparam int CLK_PERIOD = 20;
  // Upper bound on issued ops, divides dominate the run time
  localparam int N_OPS = 220;
  localparam int WATCHDOG_TIME = (N_OPS * (ex_pkg::DIV_CYCLES + 4) + 200) * CLK_PERIOD;

  logic clk;
  logic rst_n;
  ex_pkg::id_ex_t id_ex;
  logic ex_mem_stall;
  logic ex_mem_flush;
  ex_pkg::ex_mem_t ex_mem;
  ex_pkg::pc_sel_t pc_sel;
  ex_pkg::word_t pc_redirect_target;
  logic op_active;

  int check_errors;
  int tb_errors;
  int tests_run;
  int tests_bad;
  logic [31:0] rng_state;

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex             (id_ex),
    .ex_mem_stall      (ex_mem_stall),
    .ex_mem_flush      (ex_mem_flush),
    .ex_mem            (ex_mem),
    .pc_sel            (pc_sel),
    .pc_redirect_target(pc_redirect_target),
    .op_active         (op_active)
  );

  ex_checker u_checker (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex             (id_ex),
    .ex_mem_stall      (ex_mem_stall),
    .ex_mem_flush      (ex_mem_flush),
    .ex_mem            (ex_mem),
    .pc_sel            (pc_sel),
    .pc_redirect_target(pc_redirect_target),
    .op_active         (op_active),
    .errors            (check_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // xorshift32 generator
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Common fields with a word aligned pc
  function automatic ex_pkg::id_ex_t base_item();
    ex_pkg::id_ex_t t;
    t = '0;
    t.instr = ex_pkg::I_NOP;
    t.rd = ex_pkg::REG_ADDR_W'(next_rand());
    t.rs2 = ex_pkg::REG_ADDR_W'(next_rand());
    t.rs1_data = next_rand();
    t.rs2_data = next_rand();
    t.imm = next_rand();
    t.pc = {30'(next_rand()), 2'b00};
    t.pc_plus4 = t.pc + 32'd4;
    t.ctrl.reg_write = 1'b1;
    t.ctrl.res_src = 3'(next_rand());
    return t;
  endfunction

  // One id_ex value per rising edge
  task automatic apply(input ex_pkg::id_ex_t v, input logic stall, input logic flush);
    @(posedge clk);
    id_ex <= v;
    ex_mem_stall <= stall;
    ex_mem_flush <= flush;
  endtask

  // Divide with the stall held over the op_active window
  task automatic run_divide(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
    ex_pkg::id_ex_t t;
    int n;
    int guard;
    t = base_item();
    t.ctrl.is_mc = 1'b1;
    t.ctrl.res_src = 3'd4;
    t.instr = {7'b0000001, 10'h0, f3, 12'h033};
    t.funct3 = f3;
    t.funct7 = 7'b0000001;
    t.rs1_data = a;
    t.rs2_data = b;
    apply(t, 1'b1, 1'b0);
    n = 0;
    guard = 0;
    // Count the window mid-cycle
    while (n < ex_pkg::DIV_CYCLES + 1 && guard < ex_pkg::DIV_CYCLES + 10) begin
      @(negedge clk);
      if (op_active) n++;
      guard++;
    end
    if (n < ex_pkg::DIV_CYCLES + 1) begin
      $display("divide op_active never covered the expected window at %0t", $time);
      tb_errors++;
    end
    // Capture cycle follows with the stall released
    @(posedge clk);
    ex_mem_stall <= 1'b0;
  endtask

  // Few idle cycles so the checker sees the last result, then one line
  task automatic finish_test(input string name, input int errs_before);
    ex_pkg::id_ex_t t;
    int delta;
    t = '0;
    t.instr = ex_pkg::I_NOP;
    apply(t, 1'b0, 1'b0);
    apply(t, 1'b0, 1'b0);
    @(posedge clk);
    delta = check_errors + tb_errors - errs_before;
    tests_run++;
    if (delta != 0) tests_bad++;
    $display("test %0d %s: %s (%0d errors)", tests_run, name, (delta == 0) ? "ok" : "bad", delta);
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired, the run did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    ex_pkg::id_ex_t t;
    int e0;
    logic [2:0] f3s [4];
    rng_state = 32'd16478;
    tb_errors = 0;
    tests_run = 0;
    tests_bad = 0;
    id_ex = '0;
    ex_mem_stall = 1'b0;
    ex_mem_flush = 1'b0;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // ALU, every funct3 in both forms and with all A sources
    e0 = check_errors + tb_errors;
    for (int i = 0; i < 72; i++) begin
      t = base_item();
      t.funct3 = 3'(i % 8);
      t.funct7 = {1'b0, next_rand() % 2 == 0, 5'b0};
      t.ctrl.alu_instr = ex_pkg::ALU_FUNCT;
      t.ctrl.alu_b_src = ((i / 8) % 2 == 0);
      t.ctrl.alu_a_src = ex_pkg::alu_a_sel_t'((i / 16) % 3);
      t.instr = {t.funct7, 10'h0, t.funct3, 5'h0, t.ctrl.alu_b_src ? 7'h13 : 7'h33};
      apply(t, 1'b0, 1'b0);
    end
    finish_test("alu", e0);

    // Conditional branches and JAL, some with misaligned targets
    e0 = check_errors + tb_errors;
    for (int i = 0; i < 56; i++) begin
      t = base_item();
      t.ctrl.reg_write = 1'b0;
      t.imm = {30'(next_rand()), next_rand() % 4 == 0, 1'b0};
      if (i < 48) begin
        t.funct3 = (i % 6 < 2) ? 3'(i % 6) : 3'(i % 6 + 2);
        t.ctrl.is_branch = 1'b1;
        t.ctrl.alu_instr = ex_pkg::ALU_BRANCH;
        if (next_rand() % 3 == 0) t.rs2_data = t.rs1_data;
        t.instr = {17'h0, t.funct3, 12'h063};
      end else begin
        t.ctrl.is_jal = 1'b1;
        t.ctrl.reg_write = 1'b1;
        t.instr = 32'h0000_006f;
      end
      apply(t, 1'b0, 1'b0);
    end
    finish_test("branch_jal", e0);

    // JALR target and trap
    e0 = check_errors + tb_errors;
    for (int i = 0; i < 16; i++) begin
      t = base_item();
      t.ctrl.is_jalr = 1'b1;
      t.ctrl.jb_target_src = 1'b1;
      t.ctrl.alu_b_src = 1'b1;
      t.ctrl.alu_instr = ex_pkg::ALU_ADD;
      t.instr = 32'h0000_0067;
      apply(t, 1'b0, 1'b0);
    end
    finish_test("jalr", e0);

    // Divide and remainder
    e0 = check_errors + tb_errors;
    f3s = '{ex_pkg::F3_DIV, ex_pkg::F3_DIVU, ex_pkg::F3_REM, ex_pkg::F3_REMU};
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 5; i++) run_divide(f3s[k], next_rand(), next_rand() >> (i * 6));
      run_divide(f3s[k], next_rand(), 32'h0);
      run_divide(f3s[k], 32'h8000_0000, 32'hffff_ffff);
    end
    finish_test("divide", e0);

    // Flush bubble, then stall hold
    e0 = check_errors + tb_errors;
    t = base_item();
    t.ctrl.mem_read = 1'b1;
    t.ctrl.mem_write = 1'b1;
    apply(t, 1'b0, 1'b1);
    t = base_item();
    t.ctrl.mem_read = 1'b1;
    apply(t, 1'b0, 1'b0);
    apply(base_item(), 1'b1, 1'b0);
    apply(base_item(), 1'b1, 1'b1);
    apply(base_item(), 1'b0, 1'b0);
    finish_test("stall_flush", e0);

    $display("summary: %0d tests, %0d failing, %0d check errors, %0d other errors",
             tests_run, tests_bad, check_errors, tb_errors);
    if (check_errors == 0 && tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_divider.sv
hdl/ex_mem_reg.sv
hdl/ex_stage.sv
test/ex_stage_asserts.sv
test/ex_checker.sv
test/ex_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the EX stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module ex_stage_tb -o ex_sim \
  && ./obj_dir/ex_sim | tee /dev/stderr | grep -q "^Simulation passed$" \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }
